/* core_mem_pkg.sv */
// Two banks only, one address bit picks the bank; LBUF depth must be a power of two
`default_nettype none

package core_mem_pkg;

    // ==================================================================
    // Sizes
    // ==================================================================

    // Bank picked by a single GBUS address bit
    localparam int NUM_BANKS = 2;

    localparam int DEF_GBUS_DATA  = 32;    // GBUS and LBUF word width
    localparam int DEF_GBUS_ADDR  = 12;    // GBUS and CMEM address width
    localparam int DEF_BANK_DEPTH = 256;   // Words per bank, WMEM and cache alike
    localparam int DEF_LBUF_DEPTH = 16;    // Power of two

    // ==================================================================
    // Encodings
    // ==================================================================

    // Value of the top address bit
    typedef enum logic [0:0] {
        BANK_WMEM  = 1'b0,
        BANK_CACHE = 1'b1
    } bank_id_e;

    // Requester that issued a bank read
    typedef enum logic [0:0] {
        OWN_GBUS = 1'b0,
        OWN_CMEM = 1'b1
    } rd_owner_e;

endpackage

`default_nettype wire

/* bank_if.sv */
// One instance per bank; BANK_DEPTH sets the word address width
`timescale 1ns/1ns
`default_nettype none

interface bank_if
    import core_mem_pkg::*;
#(
    parameter int GBUS_DATA  = DEF_GBUS_DATA,
    parameter int BANK_DEPTH = DEF_BANK_DEPTH
);
    localparam int BANK_ADDR = $clog2(BANK_DEPTH);

    logic [BANK_ADDR-1:0] addr;
    logic                 wen;
    logic [GBUS_DATA-1:0] wdata;
    logic                 ren;
    rd_owner_e            rd_owner;   // Who asked for this read
    logic [GBUS_DATA-1:0] rdata;      // Valid one cycle after ren

    modport dec (output addr, wen, wdata, ren, rd_owner);
    modport mem (input addr, wen, wdata, ren, output rdata);
    modport sel (input ren, rd_owner, rdata);
endinterface

`default_nettype wire

/* bank_port_decode.sv */
// Purely combinational; assumes gbus_wen and gbus_ren never high together
`timescale 1ns/1ns
`default_nettype none

module bank_port_decode
    import core_mem_pkg::*;
#(
    parameter int GBUS_DATA  = DEF_GBUS_DATA,
    parameter int GBUS_ADDR  = DEF_GBUS_ADDR,
    parameter int BANK_DEPTH = DEF_BANK_DEPTH
)(
    input  wire logic [GBUS_ADDR-1:0] gbus_addr,
    input  wire logic                 gbus_wen,
    input  wire logic [GBUS_DATA-1:0] gbus_wdata,
    input  wire logic                 gbus_ren,
    input  wire logic [GBUS_ADDR-1:0] cmem_raddr,
    input  wire logic                 cmem_ren,
    bank_if.dec                       banks [NUM_BANKS]
);

    localparam int BANK_ADDR = $clog2(BANK_DEPTH);

    bank_id_e gbus_bank;
    bank_id_e cmem_bank;

    // Top address bit names the bank
    assign gbus_bank = bank_id_e'(gbus_addr[GBUS_ADDR-1]);
    assign cmem_bank = bank_id_e'(cmem_raddr[GBUS_ADDR-1]);

    // ==================================================================
    // Per-bank port arbitration
    // ==================================================================
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        localparam bank_id_e THIS_BANK = bank_id_e'(1'(b));

        logic g_wr;
        logic g_rd;
        logic c_rd;

        // Write wins, then GBUS read, then CMEM read
        assign g_wr = gbus_wen && (gbus_bank == THIS_BANK);
        assign g_rd = gbus_ren && !gbus_wen && (gbus_bank == THIS_BANK);
        assign c_rd = cmem_ren && (cmem_bank == THIS_BANK) && !g_wr && !g_rd;

        assign banks[b].addr  = (g_wr || g_rd) ? gbus_addr[BANK_ADDR-1:0]
                                               : cmem_raddr[BANK_ADDR-1:0];
        assign banks[b].wen   = g_wr;
        assign banks[b].wdata = gbus_wdata;
        assign banks[b].ren   = g_rd || c_rd;   // Dropped CMEM read never reaches the bank

        // Tag travels with the read so the selector knows where data goes
        assign banks[b].rd_owner = g_rd ? OWN_GBUS : OWN_CMEM;
    end

endmodule

`default_nettype wire

/* mem_bank.sv */
// Single-port bank, no read-during-write on the same cycle; contents undefined after power-up
`timescale 1ns/1ns
`default_nettype none

module mem_bank
    import core_mem_pkg::*;
#(
    parameter int GBUS_DATA  = DEF_GBUS_DATA,
    parameter int BANK_DEPTH = DEF_BANK_DEPTH
)(
    input  wire logic clk,
    bank_if.mem       port
);

    logic [GBUS_DATA-1:0] mem [BANK_DEPTH];

    // Synchronous write
    always_ff @(posedge clk) begin
        if (port.wen) begin
            mem[port.addr] <= port.wdata;
        end
    end

    // Read register holds its word while ren is low
    always_ff @(posedge clk) begin
        if (port.ren) begin
            port.rdata <= mem[port.addr];
        end
    end

endmodule

`default_nettype wire

/* bank_read_sel.sv */
// At most one GBUS and one CMEM read per cycle, each on its own bank
`timescale 1ns/1ns
`default_nettype none

module bank_read_sel
    import core_mem_pkg::*;
#(
    parameter int GBUS_DATA = DEF_GBUS_DATA
)(
    input  wire logic                 clk,
    input  wire logic                 rstn,
    bank_if.sel                       banks [NUM_BANKS],
    output logic      [GBUS_DATA-1:0] gbus_rdata,
    output logic                      gbus_rvalid,
    output logic                      lbuf_push,
    output logic      [GBUS_DATA-1:0] lbuf_push_data
);

    logic      [NUM_BANKS-1:0] rd_vld;             // Bank read issued last cycle
    rd_owner_e                 rd_own [NUM_BANKS];
    logic      [GBUS_DATA-1:0] bank_rdata [NUM_BANKS];

    // ==================================================================
    // Track each bank read for one cycle
    // ==================================================================
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_track
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                rd_vld[b] <= 1'b0;
                rd_own[b] <= OWN_GBUS;
            end else begin
                rd_vld[b] <= banks[b].ren;
                rd_own[b] <= banks[b].rd_owner;
            end
        end

        assign bank_rdata[b] = banks[b].rdata;
    end

    // Steer by owner tag
    always_comb begin
        gbus_rdata     = '0;
        gbus_rvalid    = 1'b0;
        lbuf_push      = 1'b0;
        lbuf_push_data = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (rd_vld[b] && (rd_own[b] == OWN_GBUS)) begin
                gbus_rdata  = bank_rdata[b];
                gbus_rvalid = 1'b1;
            end
            if (rd_vld[b] && (rd_own[b] == OWN_CMEM)) begin
                lbuf_push_data = bank_rdata[b];   // Straight into LBUF write side
                lbuf_push      = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* lbuf_fifo.sv */
// LBUF_DEPTH must be a power of two; pushes while full are dropped, no back-pressure
`timescale 1ns/1ns
`default_nettype none

module lbuf_fifo
    import core_mem_pkg::*;
#(
    parameter int GBUS_DATA  = DEF_GBUS_DATA,
    parameter int LBUF_DEPTH = DEF_LBUF_DEPTH
)(
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 lbuf_push,
    input  wire logic [GBUS_DATA-1:0] lbuf_push_data,
    input  wire logic                 lbuf_ren,
    output logic      [GBUS_DATA-1:0] lbuf_rdata,
    output logic                      lbuf_rvalid,
    output logic                      lbuf_empty,
    output logic                      lbuf_full
);

    localparam int PTR_W = $clog2(LBUF_DEPTH);

    logic [GBUS_DATA-1:0] mem [LBUF_DEPTH];
    logic [PTR_W:0]       wr_ptr;   // Top bit is the wrap flag
    logic [PTR_W:0]       rd_ptr;
    logic                 push_ok;
    logic                 pop_ok;

    // ==================================================================
    // Flags from the pointers at the start of the cycle
    // ==================================================================
    assign lbuf_empty = (wr_ptr == rd_ptr);
    assign lbuf_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                        (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign push_ok = lbuf_push && !lbuf_full;
    assign pop_ok  = lbuf_ren && !lbuf_empty;   // Read of empty LBUF ignored

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            lbuf_rvalid <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            lbuf_rvalid <= pop_ok;
        end
    end

    // ==================================================================
    // Dual-port storage
    // ==================================================================
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr[PTR_W-1:0]] <= lbuf_push_data;
        end
        if (pop_ok) begin
            lbuf_rdata <= mem[rd_ptr[PTR_W-1:0]];   // Held between reads
        end
    end

endmodule

`default_nettype wire

/* core_mem.sv */
// Bank address width from BANK_DEPTH must be below GBUS_ADDR; gbus_wen and gbus_ren are exclusive
`timescale 1ns/1ns
`default_nettype none

module core_mem
    import core_mem_pkg::*;
#(
    parameter int GBUS_DATA  = DEF_GBUS_DATA,
    parameter int GBUS_ADDR  = DEF_GBUS_ADDR,
    parameter int BANK_DEPTH = DEF_BANK_DEPTH,
    parameter int LBUF_DEPTH = DEF_LBUF_DEPTH
)(
    input  wire logic                 clk,
    input  wire logic                 rstn,

    // GBUS channel
    input  wire logic [GBUS_ADDR-1:0] gbus_addr,
    input  wire logic                 gbus_wen,
    input  wire logic [GBUS_DATA-1:0] gbus_wdata,
    input  wire logic                 gbus_ren,
    output logic      [GBUS_DATA-1:0] gbus_rdata,
    output logic                      gbus_rvalid,

    // CMEM read into LBUF
    input  wire logic [GBUS_ADDR-1:0] cmem_raddr,
    input  wire logic                 cmem_ren,

    // LBUF toward the MAC
    input  wire logic                 lbuf_ren,
    output logic      [GBUS_DATA-1:0] lbuf_rdata,
    output logic                      lbuf_rvalid,
    output logic                      lbuf_empty,
    output logic                      lbuf_full
);

    logic                 lbuf_push;
    logic [GBUS_DATA-1:0] lbuf_push_data;

    bank_if #(.GBUS_DATA(GBUS_DATA), .BANK_DEPTH(BANK_DEPTH)) banks [NUM_BANKS] ();

    // ==================================================================
    // Request routing
    // ==================================================================
    bank_port_decode #(
        .GBUS_DATA  (GBUS_DATA),
        .GBUS_ADDR  (GBUS_ADDR),
        .BANK_DEPTH (BANK_DEPTH)
    ) bank_port_decode_i (
        .gbus_addr  (gbus_addr),
        .gbus_wen   (gbus_wen),
        .gbus_wdata (gbus_wdata),
        .gbus_ren   (gbus_ren),
        .cmem_raddr (cmem_raddr),
        .cmem_ren   (cmem_ren),
        .banks      (banks)
    );

    // Bank 0 is WMEM, bank 1 the KV cache
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mem_bank #(
            .GBUS_DATA  (GBUS_DATA),
            .BANK_DEPTH (BANK_DEPTH)
        ) mem_bank_i (
            .clk  (clk),
            .port (banks[b])
        );
    end

    // ==================================================================
    // Read return and LBUF
    // ==================================================================
    bank_read_sel #(
        .GBUS_DATA (GBUS_DATA)
    ) bank_read_sel_i (
        .clk            (clk),
        .rstn           (rstn),
        .banks          (banks),
        .gbus_rdata     (gbus_rdata),
        .gbus_rvalid    (gbus_rvalid),
        .lbuf_push      (lbuf_push),
        .lbuf_push_data (lbuf_push_data)
    );

    lbuf_fifo #(
        .GBUS_DATA  (GBUS_DATA),
        .LBUF_DEPTH (LBUF_DEPTH)
    ) lbuf_fifo_i (
        .clk            (clk),
        .rstn           (rstn),
        .lbuf_push      (lbuf_push),
        .lbuf_push_data (lbuf_push_data),
        .lbuf_ren       (lbuf_ren),
        .lbuf_rdata     (lbuf_rdata),
        .lbuf_rvalid    (lbuf_rvalid),
        .lbuf_empty     (lbuf_empty),
        .lbuf_full      (lbuf_full)
    );

endmodule

`default_nettype wire

/* core_mem_chk.sv */
// Bound into core_mem; rules hold only while rstn is high
`timescale 1ns/1ns
`default_nettype none

module core_mem_chk (
    input wire logic clk,
    input wire logic rstn,
    input wire logic gbus_wen,
    input wire logic gbus_ren,
    input wire logic gbus_rvalid,
    input wire logic lbuf_ren,
    input wire logic lbuf_rvalid,
    input wire logic lbuf_empty,
    input wire logic lbuf_full
);

    // ==================================================================
    // LBUF flags and read return
    // ==================================================================
    flags_exclusive_a: assert property (
        @(posedge clk) disable iff (!rstn) !(lbuf_empty && lbuf_full)
    ) else $error("LBUF reports empty and full at once");

    lbuf_rvalid_a: assert property (
        @(posedge clk) disable iff (!rstn) lbuf_rvalid == $past(lbuf_ren && !lbuf_empty)
    ) else $error("lbuf_rvalid does not match an accepted lbuf_ren one cycle earlier");

    // Read latency of exactly one cycle
    gbus_rvalid_a: assert property (
        @(posedge clk) disable iff (!rstn) gbus_rvalid == $past(gbus_ren && !gbus_wen)
    ) else $error("gbus_rvalid does not follow gbus_ren by one cycle");

endmodule

bind core_mem core_mem_chk core_mem_chk_i (
    .clk         (clk),
    .rstn        (rstn),
    .gbus_wen    (gbus_wen),
    .gbus_ren    (gbus_ren),
    .gbus_rvalid (gbus_rvalid),
    .lbuf_ren    (lbuf_ren),
    .lbuf_rvalid (lbuf_rvalid),
    .lbuf_empty  (lbuf_empty),
    .lbuf_full   (lbuf_full)
);

`default_nettype wire

/* tb_core_mem.sv */
// Fixed seed 32'h6d96; every bank word is written over GBUS before any read of it
`timescale 1ns/1ns
`default_nettype none

module tb_core_mem
    import core_mem_pkg::*;
();

    localparam int GBUS_DATA  = DEF_GBUS_DATA;
    localparam int GBUS_ADDR  = DEF_GBUS_ADDR;
    localparam int BANK_DEPTH = DEF_BANK_DEPTH;
    localparam int LBUF_DEPTH = DEF_LBUF_DEPTH;
    localparam int BANK_ADDR  = $clog2(BANK_DEPTH);
    localparam int MAX_CYCLES = 4000;               // Tests need about 1500

    logic                 clk = 1'b0;
    logic                 rstn;
    logic [GBUS_ADDR-1:0] gbus_addr;
    logic                 gbus_wen;
    logic [GBUS_DATA-1:0] gbus_wdata;
    logic                 gbus_ren;
    logic [GBUS_DATA-1:0] gbus_rdata;
    logic                 gbus_rvalid;
    logic [GBUS_ADDR-1:0] cmem_raddr;
    logic                 cmem_ren;
    logic                 lbuf_ren;
    logic [GBUS_DATA-1:0] lbuf_rdata;
    logic                 lbuf_rvalid;
    logic                 lbuf_empty;
    logic                 lbuf_full;

    logic [GBUS_DATA-1:0] model_mem [NUM_BANKS][BANK_DEPTH];
    logic [GBUS_DATA-1:0] lbuf_q [$];               // Expected LBUF contents
    logic                 push_pend;                // Accepted CMEM read, pushed next edge
    logic [GBUS_DATA-1:0] push_word;
    logic                 exp_gvld;
    logic [GBUS_DATA-1:0] exp_gdata;
    logic                 exp_lvld;
    logic [GBUS_DATA-1:0] exp_ldata;
    int                   value_errors = 0;
    int                   other_errors = 0;
    int                   cycle_cnt = 0;

    always #5 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    core_mem #(
        .GBUS_DATA  (GBUS_DATA),
        .GBUS_ADDR  (GBUS_ADDR),
        .BANK_DEPTH (BANK_DEPTH),
        .LBUF_DEPTH (LBUF_DEPTH)
    ) core_mem_i (.*);

    function automatic logic [GBUS_DATA-1:0] ref_read(input logic [GBUS_ADDR-1:0] addr);
        return model_mem[addr[GBUS_ADDR-1]][addr[BANK_ADDR-1:0]];
    endfunction

    function automatic logic [GBUS_ADDR-1:0] make_addr(input logic bank, input int word);
        logic [GBUS_ADDR-1:0] a;
        a = '0;
        a[GBUS_ADDR-1] = bank;                      // Bank bit
        a[BANK_ADDR-1:0] = word[BANK_ADDR-1:0];
        return a;
    endfunction

    function automatic logic [GBUS_ADDR-1:0] rand_addr();
        return make_addr(1'($urandom % 2), int'($urandom % BANK_DEPTH));
    endfunction

    function automatic void report(input string what, input logic [GBUS_DATA-1:0] got,
                                   input logic [GBUS_DATA-1:0] exp);
        value_errors++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    endfunction

    // ==================================================================
    // Reference model, stepped on the same edges as the DUT
    // ==================================================================
    always @(posedge clk) begin : ref_model
        logic full_now;
        logic empty_now;
        logic blocked;
        if (!rstn) begin
            lbuf_q.delete();
            push_pend = 1'b0;
            exp_gvld  = 1'b0;
            exp_lvld  = 1'b0;
        end else begin
            full_now  = (lbuf_q.size() == LBUF_DEPTH);  // Flags as at cycle start
            empty_now = (lbuf_q.size() == 0);
            exp_lvld  = lbuf_ren && !empty_now;
            if (exp_lvld) begin
                exp_ldata = lbuf_q.pop_front();
            end
            if (push_pend && !full_now) begin
                lbuf_q.push_back(push_word);            // Push to a full LBUF is lost
            end
            // GBUS takes the port of the bank it addresses
            blocked   = (gbus_wen || gbus_ren) &&
                        (gbus_addr[GBUS_ADDR-1] == cmem_raddr[GBUS_ADDR-1]);
            push_pend = cmem_ren && !blocked;
            push_word = ref_read(cmem_raddr);
            exp_gvld  = gbus_ren;
            exp_gdata = ref_read(gbus_addr);
            if (gbus_wen) begin
                model_mem[gbus_addr[GBUS_ADDR-1]][gbus_addr[BANK_ADDR-1:0]] = gbus_wdata;
            end
        end
    end

    // Outputs settle long before the falling edge
    always @(negedge clk) begin : compare
        if (rstn) begin
            assert (gbus_rvalid === exp_gvld) else report("gbus_rvalid", gbus_rvalid, exp_gvld);
            assert (!exp_gvld || gbus_rdata === exp_gdata)
                else report("gbus_rdata", gbus_rdata, exp_gdata);
            assert (lbuf_rvalid === exp_lvld) else report("lbuf_rvalid", lbuf_rvalid, exp_lvld);
            assert (!exp_lvld || lbuf_rdata === exp_ldata)
                else report("lbuf_rdata", lbuf_rdata, exp_ldata);
            assert (lbuf_empty === (lbuf_q.size() == 0))
                else report("lbuf_empty", lbuf_empty, lbuf_q.size() == 0);
            assert (lbuf_full === (lbuf_q.size() == LBUF_DEPTH))
                else report("lbuf_full", lbuf_full, lbuf_q.size() == LBUF_DEPTH);
        end
    end

    // ==================================================================
    // Stimulus
    // ==================================================================
    task automatic tick();                          // Strobes last one cycle
        @(posedge clk);
        #1;
        gbus_wen = 1'b0;
        gbus_ren = 1'b0;
        cmem_ren = 1'b0;
        lbuf_ren = 1'b0;
    endtask

    task automatic gbus_write(input logic [GBUS_ADDR-1:0] addr,
                              input logic [GBUS_DATA-1:0] data);
        tick();
        gbus_addr  = addr;
        gbus_wdata = data;
        gbus_wen   = 1'b1;
    endtask

    task automatic gbus_read(input logic [GBUS_ADDR-1:0] addr);
        tick();
        gbus_addr = addr;
        gbus_ren  = 1'b1;
    endtask

    task automatic cmem_read(input logic [GBUS_ADDR-1:0] addr);
        tick();
        cmem_raddr = addr;
        cmem_ren   = 1'b1;
    endtask

    task automatic lbuf_read();
        tick();
        lbuf_ren = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic drain_lbuf();
        int guard;
        guard = 0;
        do begin
            lbuf_read();
            guard++;
        end while (!lbuf_empty && guard < 4 * LBUF_DEPTH);
        assert (lbuf_empty) else begin
            other_errors++;
            $display("LBUF never went empty while being drained");
        end
        idle(1);
    endtask

    task automatic check_flags(input logic exp_empty, input logic exp_full, input string what);
        @(negedge clk);
        assert (lbuf_empty === exp_empty && lbuf_full === exp_full)
            else report({what, " empty/full"}, {lbuf_empty, lbuf_full}, {exp_empty, exp_full});
    endtask

    task automatic random_cycle();
        int op;
        tick();
        op = int'($urandom % 3);
        gbus_addr  = rand_addr();
        gbus_wdata = $urandom;
        gbus_wen   = (op == 1);
        gbus_ren   = (op == 2);
        cmem_raddr = rand_addr();
        cmem_ren   = 1'($urandom % 2);
        lbuf_ren   = (($urandom % 3) == 0);
    endtask

    initial begin : watchdog
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [GBUS_DATA-1:0] d;
        void'($urandom(32'h6d96));
        rstn       = 1'b0;
        gbus_addr  = '0;
        gbus_wen   = 1'b0;
        gbus_wdata = '0;
        gbus_ren   = 1'b0;
        cmem_raddr = '0;
        cmem_ren   = 1'b0;
        lbuf_ren   = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_flags(1'b1, 1'b0, "after reset");
        assert (!gbus_rvalid && !lbuf_rvalid) else report("valids after reset", 1, 0);

        // Fill both banks, then random traffic and a bank bit alias pair
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < BANK_DEPTH; w++) begin
                gbus_write(make_addr(1'(b), w), $urandom);
            end
        end
        repeat (64) gbus_write(rand_addr(), $urandom);
        repeat (128) gbus_read(rand_addr());
        d = $urandom;
        gbus_write(make_addr(1'b0, 17), d);
        gbus_write(make_addr(1'b1, 17), ~d);
        gbus_read(make_addr(1'b0, 17));
        gbus_read(make_addr(1'b1, 17));

        // CMEM burst and drain
        repeat (8) cmem_read(rand_addr());
        idle(2);
        check_flags(1'b0, 1'b0, "after CMEM burst");
        drain_lbuf();
        check_flags(1'b1, 1'b0, "after drain");

        // Overfill, drain, then reads of an empty LBUF
        repeat (LBUF_DEPTH + 3) cmem_read(rand_addr());
        idle(2);
        check_flags(1'b0, 1'b1, "after overfill");
        drain_lbuf();
        repeat (3) lbuf_read();
        idle(2);
        check_flags(1'b1, 1'b0, "after empty reads");

        // Same bank conflicts, then reads of different banks
        repeat (6) begin
            cmem_read(make_addr(1'b0, int'($urandom % BANK_DEPTH)));
            gbus_addr = make_addr(1'b0, int'($urandom % BANK_DEPTH));
            gbus_ren  = 1'b1;
        end
        idle(2);
        check_flags(1'b1, 1'b0, "after same bank conflicts");
        repeat (6) begin
            d = $urandom % 2;
            cmem_read(make_addr(d[0], int'($urandom % BANK_DEPTH)));
            gbus_addr = make_addr(!d[0], int'($urandom % BANK_DEPTH));
            gbus_ren  = 1'b1;
        end
        idle(2);
        check_flags(1'b0, 1'b0, "after split bank reads");
        drain_lbuf();

        // Push and pop together on a partly filled LBUF
        repeat (6) cmem_read(rand_addr());
        idle(2);
        repeat (40) begin
            cmem_read(rand_addr());
            lbuf_ren = 1'b1;
        end
        idle(2);
        drain_lbuf();

        repeat (500) random_cycle();
        idle(2);
        drain_lbuf();
        idle(2);

        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
core_mem_pkg.sv
bank_if.sv
bank_port_decode.sv
mem_bank.sv
bank_read_sel.sv
lbuf_fifo.sv
core_mem.sv
core_mem_chk.sv
tb_core_mem.sv

/* Makefile */
# Verilator build and run of the core memory testbench

VERILATOR ?= verilator
TOP       ?= tb_core_mem
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
